/* common/cache_geom_pkg.sv */
// geometry of the two-way instruction cache
// 4 KiB total, 64-byte lines of sixteen 32-bit words
// all widths below derive from the first five values; changing them
// is untested beyond the two-way case (hit_select encodes two ways)

package cache_geom_pkg;

   localparam int addr_w      = 32;
   localparam int word_w      = 32;
   localparam int line_words  = 16;
   localparam int num_ways    = 2;
   localparam int cache_bytes = 4096;

   // derived sizes
   localparam int num_sets   = cache_bytes / (num_ways * line_words * (word_w / 8));
   localparam int offset_w   = $clog2(line_words * (word_w / 8));
   localparam int word_sel_w = $clog2(line_words);
   localparam int index_w    = $clog2(num_sets);
   localparam int tag_w      = addr_w - index_w - offset_w;
   // one extra bit so the count can reach line_words
   localparam int beat_cnt_w = $clog2(line_words) + 1;

   typedef logic [addr_w-1:0]  addr_t;
   typedef logic [tag_w-1:0]   tag_t;
   typedef logic [index_w-1:0] index_t;
   typedef logic [word_w-1:0]  word_t;

   // word 0 sits in the low bits
   typedef word_t [line_words-1:0] line_t;

   typedef struct packed {
      tag_t                tag;
      index_t              index;
      logic [offset_w-1:0] offset;
   } addr_fields_t;

   // flat view for the memory side, field view for the lookup
   typedef union packed {
      addr_t        flat;
      addr_fields_t fields;
   } cache_addr_u;

endpackage

/* common/cache_bus_pkg.sv */
// payload types of the CPU and memory ports
// valid and ready travel as separate single-bit ports next to these
// memory answers one line request with sixteen beats in word order

package cache_bus_pkg;

   import cache_geom_pkg::*;

   // cpu read request, byte address of the wanted word
   typedef struct packed {
      cache_addr_u addr;
   } cpu_req_t;

   // word returned to the cpu
   typedef struct packed {
      word_t data;
   } cpu_resp_t;

   // line request, low offset bits always zero
   typedef struct packed {
      addr_t addr;
   } mem_req_t;

   // one word of a refill burst
   typedef struct packed {
      word_t data;
   } mem_beat_t;

endpackage

/* logic/hit_select.sv */
// tag compare over both ways and word pick from the hitting line
// purely combinational; the caller decides when hit is meaningful
// hit_way encoding assumes exactly two ways

`timescale 1ns/1ps

module hit_select
   import cache_geom_pkg::*;
(
   input  tag_t                  lookup_tag,
   input  logic [word_sel_w-1:0] word_sel,
   input  tag_t  [num_ways-1:0]  way_tag,
   input  logic  [num_ways-1:0]  way_valid,
   input  line_t [num_ways-1:0]  way_line,
   output logic                  hit,
   output logic                  hit_way,
   output word_t                 hit_word
);

   logic [num_ways-1:0] way_match;

   // a way matches only when valid and its tag agrees
   always_comb begin
      for (int w = 0; w < num_ways; w++) begin
         way_match[w] = way_valid[w] && (way_tag[w] == lookup_tag);
      end
   end

   assign hit = |way_match;

   // one line is never held in both ways, so way 1 alone decides
   assign hit_way = way_match[1];

   assign hit_word = way_line[hit_way][word_sel];

endmodule

/* icache/set_store.sv */
// tag, line, valid and lru storage for both ways
// reads are registered: index sampled on one edge, data valid after it
// writes use the same index as the read, so the fill must happen
// while the lookup address still names the filled set
// invalidate_all wins over a fill setting a valid bit

`timescale 1ns/1ps

module set_store
   import cache_geom_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  index_t               lookup_index,
   input  logic                 fill_en,
   input  logic                 fill_way,
   input  tag_t                 fill_tag,
   input  line_t                fill_line,
   input  logic                 lru_we,
   input  logic                 lru_next,
   input  logic                 invalidate_all,
   output tag_t  [num_ways-1:0] way_tag,
   output logic  [num_ways-1:0] way_valid,
   output line_t [num_ways-1:0] way_line,
   output logic                 lru
);

   tag_t  tag_mem  [num_ways][num_sets];
   line_t line_mem [num_ways][num_sets];

   logic [num_sets-1:0][num_ways-1:0] valid_q;
   // per set, the way not used most recently
   logic [num_sets-1:0]               lru_q;

   // synchronous-read arrays, read before write
   always_ff @(posedge clk) begin
      for (int w = 0; w < num_ways; w++) begin
         if (fill_en && fill_way == w[0]) begin
            tag_mem[w][lookup_index]  <= fill_tag;
            line_mem[w][lookup_index] <= fill_line;
         end
         way_tag[w]  <= tag_mem[w][lookup_index];
         way_line[w] <= line_mem[w][lookup_index];
      end
   end

   always_ff @(posedge clk) begin
      if (reset || invalidate_all) begin
         valid_q <= '0;
      end else if (fill_en) begin
         valid_q[lookup_index][fill_way] <= 1'b1;
      end
   end

   // reset points every set at way 0
   always_ff @(posedge clk) begin
      if (reset) begin
         lru_q <= '0;
      end else if (lru_we) begin
         lru_q[lookup_index] <= lru_next;
      end
   end

   // registered flag reads, aligned with the array reads
   always_ff @(posedge clk) begin
      if (reset) begin
         way_valid <= '0;
         lru       <= 1'b0;
      end else begin
         way_valid <= valid_q[lookup_index];
         lru       <= lru_q[lookup_index];
      end
   end

endmodule

/* icache/refill_buffer.sv */
// gathers the sixteen beats of one refill burst into a line
// beats shift in from the top, so beat 0 ends up as word 0
// done follows the sixteenth beat and holds until clear
// beats past the sixteenth are ignored

`timescale 1ns/1ps

module refill_buffer
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  clear,
   input  logic                  mem_beat_valid,
   input  mem_beat_t             mem_beat,
   input  logic [word_sel_w-1:0] word_sel,
   output line_t                 line,
   output logic                  done,
   output word_t                 refill_word
);

   logic [beat_cnt_w-1:0] beat_cnt;
   logic                  take_beat;

   assign done      = (beat_cnt == beat_cnt_w'(line_words));
   assign take_beat = mem_beat_valid && !done;

   // beat counter
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         beat_cnt <= '0;
      end else if (take_beat) begin
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

   // line shift register, newest word on top
   always_ff @(posedge clk) begin
      if (take_beat) begin
         line <= {mem_beat.data, line[line_words-1:1]};
      end
   end

   // requested word, only meaningful once done is high
   assign refill_word = line[word_sel];

endmodule

/* icache/icache_ctrl.sv */
// transaction FSM of the instruction cache
// lookup_addr shows the live request in idle so the registered set
// read lands in the lookup cycle; afterwards it holds the captured one
// after a flush during refill no request is taken until the aborted
// burst has fully arrived

`timescale 1ns/1ps

module icache_ctrl
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        flush,
   input  logic        cpu_req_valid,
   input  cpu_req_t    cpu_req,
   input  logic        cpu_resp_ready,
   input  logic        mem_req_ready,
   input  logic        hit,
   input  logic        hit_way,
   input  word_t       hit_word,
   input  logic        lru,
   input  logic        refill_done,
   input  word_t       refill_word,
   output logic        cpu_req_ready,
   output logic        cpu_resp_valid,
   output cpu_resp_t   cpu_resp,
   output logic        mem_req_valid,
   output mem_req_t    mem_req,
   output cache_addr_u lookup_addr,
   output logic        fill_en,
   output logic        fill_way,
   output logic        lru_we,
   output logic        lru_next,
   output logic        refill_clear,
   output logic        invalidate_all
);

   typedef enum logic [2:0] {
      st_idle,
      st_lookup,
      st_request,
      st_refill,
      st_respond
   } state_t;

   state_t      state;
   logic        mem_busy;
   cache_addr_u addr_q;
   word_t       resp_word;
   logic        way_q;
   logic        miss_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= st_idle;
         mem_busy <= 1'b0;
      end else begin
         // burst outstanding from accept until the last beat
         if (mem_req_valid && mem_req_ready) begin
            mem_busy <= 1'b1;
         end else if (refill_done) begin
            mem_busy <= 1'b0;
         end

         if (flush) begin
            state <= st_idle;
         end else begin
            case (state)
               st_idle:    if (cpu_req_valid && cpu_req_ready) state <= st_lookup;
               st_lookup:  state <= hit ? st_respond : st_request;
               st_request: if (mem_req_ready) state <= st_refill;
               st_refill:  if (refill_done) state <= st_respond;
               st_respond: if (cpu_resp_ready) state <= st_idle;
               default:    state <= st_idle;
            endcase
         end
      end
   end

   // request address, used way and response word
   always_ff @(posedge clk) begin
      if (state == st_idle && cpu_req_valid && cpu_req_ready) begin
         addr_q <= cpu_req.addr;
      end
      if (state == st_lookup) begin
         // victim on a miss is the way the lru bit names
         way_q  <= hit ? hit_way : lru;
         miss_q <= !hit;
         if (hit) begin
            resp_word <= hit_word;
         end
      end
      if (state == st_refill && refill_done) begin
         resp_word <= refill_word;
      end
   end

   assign lookup_addr    = (state == st_idle) ? cpu_req.addr : addr_q;
   assign cpu_req_ready  = (state == st_idle) && !mem_busy;
   assign cpu_resp_valid = (state == st_respond);
   assign cpu_resp.data  = resp_word;

   // line-aligned request from the flat view
   assign mem_req_valid = (state == st_request);
   assign mem_req.addr  = {addr_q.flat[addr_w-1:offset_w], {offset_w{1'b0}}};

   // count restarts on the lookup to request transition
   assign refill_clear = (state == st_lookup) && !hit;

   // fill and lru update on the response transfer
   assign fill_en        = (state == st_respond) && cpu_resp_ready && miss_q;
   assign fill_way       = way_q;
   assign lru_we         = (state == st_respond) && cpu_resp_ready;
   assign lru_next       = ~way_q;
   assign invalidate_all = flush;

endmodule

/* icache/icache_top.sv */
// two-way set-associative read-only instruction cache
// hit: response valid one cycle after the request transfer
// miss: one 64-byte line request, sixteen beats, response one cycle later
// flush is a one-cycle pulse that aborts and invalidates everything

`timescale 1ns/1ps

module icache_top
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      flush,
   input  logic      cpu_req_valid,
   output logic      cpu_req_ready,
   input  cpu_req_t  cpu_req,
   output logic      cpu_resp_valid,
   input  logic      cpu_resp_ready,
   output cpu_resp_t cpu_resp,
   output logic      mem_req_valid,
   input  logic      mem_req_ready,
   output mem_req_t  mem_req,
   input  logic      mem_beat_valid,
   input  mem_beat_t mem_beat
);

   cache_addr_u             lookup_addr;
   logic                    fill_en;
   logic                    fill_way;
   logic                    lru_we;
   logic                    lru_next;
   logic                    refill_clear;
   logic                    invalidate_all;
   tag_t [num_ways-1:0]     way_tag;
   logic [num_ways-1:0]     way_valid;
   line_t [num_ways-1:0]    way_line;
   logic                    lru;
   logic                    hit;
   logic                    hit_way;
   word_t                   hit_word;
   line_t                   refill_line;
   logic                    refill_done;
   word_t                   refill_word;

   icache_ctrl u_ctrl (
      .clk            (clk),
      .reset          (reset),
      .flush          (flush),
      .cpu_req_valid  (cpu_req_valid),
      .cpu_req        (cpu_req),
      .cpu_resp_ready (cpu_resp_ready),
      .mem_req_ready  (mem_req_ready),
      .hit            (hit),
      .hit_way        (hit_way),
      .hit_word       (hit_word),
      .lru            (lru),
      .refill_done    (refill_done),
      .refill_word    (refill_word),
      .cpu_req_ready  (cpu_req_ready),
      .cpu_resp_valid (cpu_resp_valid),
      .cpu_resp       (cpu_resp),
      .mem_req_valid  (mem_req_valid),
      .mem_req        (mem_req),
      .lookup_addr    (lookup_addr),
      .fill_en        (fill_en),
      .fill_way       (fill_way),
      .lru_we         (lru_we),
      .lru_next       (lru_next),
      .refill_clear   (refill_clear),
      .invalidate_all (invalidate_all)
   );

   // fills land in the set of the current lookup address
   set_store u_set_store (
      .clk            (clk),
      .reset          (reset),
      .lookup_index   (lookup_addr.fields.index),
      .fill_en        (fill_en),
      .fill_way       (fill_way),
      .fill_tag       (lookup_addr.fields.tag),
      .fill_line      (refill_line),
      .lru_we         (lru_we),
      .lru_next       (lru_next),
      .invalidate_all (invalidate_all),
      .way_tag        (way_tag),
      .way_valid      (way_valid),
      .way_line       (way_line),
      .lru            (lru)
   );

   hit_select u_hit_select (
      .lookup_tag (lookup_addr.fields.tag),
      .word_sel   (lookup_addr.fields.offset[offset_w-1 -: word_sel_w]),
      .way_tag    (way_tag),
      .way_valid  (way_valid),
      .way_line   (way_line),
      .hit        (hit),
      .hit_way    (hit_way),
      .hit_word   (hit_word)
   );

   refill_buffer u_refill_buffer (
      .clk            (clk),
      .reset          (reset),
      .clear          (refill_clear),
      .mem_beat_valid (mem_beat_valid),
      .mem_beat       (mem_beat),
      .word_sel       (lookup_addr.fields.offset[offset_w-1 -: word_sel_w]),
      .line           (refill_line),
      .done           (refill_done),
      .refill_word    (refill_word)
   );

endmodule

/* verif/icache_model.svh */
// reference model of the cache state and the compare tasks
// tracks tags, valid bits and lru bits per set; data follows the memory rule
// flush clears the valid bits and leaves the lru bits as they are

`ifndef ICACHE_MODEL_SVH
`define ICACHE_MODEL_SVH

localparam word_t mem_pattern = 32'hc3a5_5a3c;

tag_t m_tag   [num_ways][num_sets];
logic m_valid [num_ways][num_sets];
logic m_lru   [num_sets];
int   err_count   = 0;
int   check_count = 0;

// byte address of the word xor a fixed pattern
function automatic word_t mem_word(input addr_t a);
   return {a[addr_w-1:2], 2'b00} ^ mem_pattern;
endfunction

// start of the 64-byte line holding the address
function automatic addr_t line_addr(input addr_t a);
   return a & ~addr_t'(line_words * 4 - 1);
endfunction

task automatic model_reset();
   for (int s = 0; s < num_sets; s++) begin
      m_valid[0][s] = 1'b0;
      m_valid[1][s] = 1'b0;
      m_lru[s]      = 1'b0;
   end
endtask

task automatic model_flush();
   for (int s = 0; s < num_sets; s++) begin
      m_valid[0][s] = 1'b0;
      m_valid[1][s] = 1'b0;
   end
endtask

// hit way, or the lru victim on a miss
task automatic model_lookup(input addr_t a, output logic hit, output logic way);
   index_t idx;
   tag_t   tg;
   idx = a[offset_w +: index_w];
   tg  = a[addr_w-1 -: tag_w];
   hit = 1'b0;
   way = m_lru[idx];
   for (int w = 0; w < num_ways; w++) begin
      if (m_valid[w][idx] && m_tag[w][idx] == tg) begin
         hit = 1'b1;
         way = w[0];
      end
   end
endtask

// state change on the response transfer
task automatic model_commit(input addr_t a, input logic hit, input logic way);
   index_t idx;
   idx = a[offset_w +: index_w];
   if (!hit) begin
      m_tag[way][idx]   = a[addr_w-1 -: tag_w];
      m_valid[way][idx] = 1'b1;
   end
   m_lru[idx] = ~way;
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
   check_count++;
   if (got !== exp) begin
      err_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

task automatic check_mem_addr(input string name, input addr_t got, input addr_t exp);
   check_count++;
   if (got !== exp) begin
      err_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

// a hit shows as no memory request
task automatic check_hit(input string name, input logic req_seen, input logic exp_hit);
   check_count++;
   if (req_seen !== !exp_hit) begin
      err_count++;
      $display("mismatch %s: got %h expected %h", name, req_seen, !exp_hit);
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   check_count++;
   if (got !== exp) begin
      err_count++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

task automatic note_failure(input string msg);
   check_count++;
   err_count++;
   $display("error: %s", msg);
endtask

`endif

/* verif/icache_tb.sv */
// testbench for the two-way instruction cache
// inputs change on falling clock edges and outputs are sampled there too
// memory answers with each word's byte address xor a fixed pattern
// accesses use three tags over two sets so evictions stay frequent
// a watchdog bounds the run from the access count and worst refill time

`timescale 1ns/1ps

module icache_tb
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;
();

   localparam int clk_period   = 40;
   localparam int n_random     = 300;
   localparam int max_grant    = 4;
   localparam int max_gap      = 3;
   localparam int max_stall    = 4;
   localparam int worst_cycles = max_grant + line_words * (max_gap + 1) + max_stall + 60;
   localparam int timeout_ns   = (n_random + 20) * worst_cycles * clk_period * 2;

   logic      clk;
   logic      reset;
   logic      flush;
   logic      cpu_req_valid;
   logic      cpu_req_ready;
   cpu_req_t  cpu_req;
   logic      cpu_resp_valid;
   logic      cpu_resp_ready;
   cpu_resp_t cpu_resp;
   logic      mem_req_valid;
   logic      mem_req_ready;
   mem_req_t  mem_req;
   logic      mem_beat_valid;
   mem_beat_t mem_beat;

   int     seed       = 18115;
   // separate stream for the memory side
   int     mem_seed   = 18116;
   int     mem_req_count = 0;
   addr_t  last_req_addr;
   time    last_beat_time;
   int     test_count = 0;
   int     test_base  = 0;
   tag_t   tag_pool [3];
   index_t set_pool [2];

   `include "icache_model.svh"

   icache_top uut (
      .clk            (clk),
      .reset          (reset),
      .flush          (flush),
      .cpu_req_valid  (cpu_req_valid),
      .cpu_req_ready  (cpu_req_ready),
      .cpu_req        (cpu_req),
      .cpu_resp_valid (cpu_resp_valid),
      .cpu_resp_ready (cpu_resp_ready),
      .cpu_resp       (cpu_resp),
      .mem_req_valid  (mem_req_valid),
      .mem_req_ready  (mem_req_ready),
      .mem_req        (mem_req),
      .mem_beat_valid (mem_beat_valid),
      .mem_beat       (mem_beat)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   function automatic addr_t make_addr(input tag_t t, input index_t i, input int w);
      return {t, i, w[word_sel_w-1:0], 2'b00};
   endfunction

   function automatic addr_t random_addr();
      return make_addr(tag_pool[{$random(seed)} % 3], set_pool[{$random(seed)} % 2],
                       {$random(seed)} % line_words);
   endfunction

   // holds valid until the cache is ready, returns after the transfer
   task automatic send_request(input addr_t a);
      cpu_req.addr.flat = a;
      cpu_req_valid     = 1'b1;
      while (!cpu_req_ready) @(negedge clk);
      @(negedge clk);
      cpu_req_valid = 1'b0;
   endtask

   task automatic pulse_flush();
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      model_flush();
   endtask

   task automatic run_access(input addr_t a, input int stall);
      logic exp_hit;
      logic exp_way;
      int   req_before;
      int   lat;
      model_lookup(a, exp_hit, exp_way);
      req_before = mem_req_count;
      send_request(a);
      // now in the lookup cycle
      lat = 0;
      while (!cpu_resp_valid) begin
         @(negedge clk);
         lat++;
      end
      if (exp_hit && lat != 1) begin
         note_failure($sformatf("hit response came %0d cycles after lookup, not 1", lat));
      end
      check_hit("mem_req_valid", mem_req_count != req_before, exp_hit);
      if (mem_req_count - req_before > 1) begin
         note_failure("more than one memory request for a single miss");
      end
      if (!exp_hit) begin
         check_mem_addr("mem_req", last_req_addr, line_addr(a));
         if ($time - last_beat_time != 2 * clk_period) begin
            note_failure("miss response did not follow the last refill beat by one cycle");
         end
      end
      // back-pressure: response and word hold, no request taken
      repeat (stall) begin
         check_flag("cpu_resp_valid", cpu_resp_valid, 1'b1);
         check_flag("cpu_req_ready", cpu_req_ready, 1'b0);
         check_word("cpu_resp", cpu_resp.data, mem_word(a));
         @(negedge clk);
      end
      check_word("cpu_resp", cpu_resp.data, mem_word(a));
      cpu_resp_ready = 1'b1;
      @(negedge clk);
      cpu_resp_ready = 1'b0;
      model_commit(a, exp_hit, exp_way);
   endtask

   task automatic abort_access(input addr_t a, input int wait_cycles);
      send_request(a);
      repeat (wait_cycles) @(negedge clk);
      pulse_flush();
      // the dropped response must never appear
      repeat (24) begin
         check_flag("cpu_resp_valid", cpu_resp_valid, 1'b0);
         @(negedge clk);
      end
   endtask

   task automatic end_test(input string name);
      test_count++;
      $display("test %s: %0d errors", name, err_count - test_base);
      test_base = err_count;
   endtask

   // memory: random grant delay, then sixteen beats with random gaps
   initial begin : memory_responder
      addr_t req_line;
      int    delay;
      int    gap;
      mem_req_ready  = 1'b0;
      mem_beat_valid = 1'b0;
      mem_beat       = '0;
      forever begin
         @(negedge clk);
         if (mem_req_valid) begin
            delay = {$random(mem_seed)} % (max_grant + 1);
            while (delay > 0 && mem_req_valid) begin
               @(negedge clk);
               delay--;
            end
            if (mem_req_valid) begin
               req_line      = mem_req.addr;
               last_req_addr = req_line;
               mem_req_count++;
               mem_req_ready = 1'b1;
               @(negedge clk);
               mem_req_ready = 1'b0;
               for (int i = 0; i < line_words; i++) begin
                  gap = {$random(mem_seed)} % (max_gap + 1);
                  repeat (gap) @(negedge clk);
                  mem_beat_valid = 1'b1;
                  mem_beat.data  = mem_word(req_line + addr_t'(i * 4));
                  last_beat_time = $time;
                  @(negedge clk);
                  mem_beat_valid = 1'b0;
               end
            end
         end
      end
   end

   initial begin : watchdog
      #(timeout_ns);
      $display("error: watchdog expired, the cache stopped responding");
      $display("TEST FAILED");
      $finish;
   end

   initial begin : stimulus
      addr_t a;
      addr_t b;
      addr_t c;
      int    kind;
      reset          = 1'b1;
      flush          = 1'b0;
      cpu_req_valid  = 1'b0;
      cpu_req        = '0;
      cpu_resp_ready = 1'b0;
      tag_pool[0] = 21'h0_1234;
      tag_pool[1] = 21'h1_0abc;
      tag_pool[2] = 21'h0_7f00;
      set_pool[0] = 5'd3;
      set_pool[1] = 5'd17;
      model_reset();
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // miss fills the line, other words of it hit
      a = make_addr(tag_pool[0], set_pool[0], 5);
      run_access(a, 0);
      run_access(a ^ 32'h18, 2);
      run_access(a, 0);
      end_test("miss_then_hit");

      // third tag in a full set evicts the lru way
      pulse_flush();
      a = make_addr(tag_pool[0], 5'd9, 0);
      b = make_addr(tag_pool[1], 5'd9, 7);
      c = make_addr(tag_pool[2], 5'd9, 15);
      run_access(a, 0);
      run_access(b, 1);
      run_access(c, 0);
      run_access(b, 0);
      run_access(a, 3);
      end_test("eviction");

      a = make_addr(tag_pool[2], set_pool[0], 1);
      b = make_addr(tag_pool[1], set_pool[1], 14);
      run_access(a, 1);
      run_access(b, 0);
      pulse_flush();
      run_access(a, 0);
      run_access(b, 3);
      abort_access(a, 2);
      abort_access(b, 10);
      run_access(b, 0);
      end_test("flush_and_abort");

      for (int i = 0; i < n_random; i++) begin
         a    = random_addr();
         kind = {$random(seed)} % 16;
         if (kind == 0) begin
            abort_access(a, {$random(seed)} % 24);
         end else if (kind == 1) begin
            pulse_flush();
         end else begin
            run_access(a, {$random(seed)} % (max_stall + 1));
         end
      end
      end_test("random");

      $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
      if (err_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+verif
common/cache_geom_pkg.sv
common/cache_bus_pkg.sv
logic/hit_select.sv
icache/set_store.sv
icache/refill_buffer.sv
icache/icache_ctrl.sv
icache/icache_top.sv
verif/icache_tb.sv

/* Bender.yml */
package:
  name: icache

sources:
  - common/cache_geom_pkg.sv
  - common/cache_bus_pkg.sv
  - logic/hit_select.sv
  - icache/set_store.sv
  - icache/refill_buffer.sv
  - icache/icache_ctrl.sv
  - icache/icache_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/icache_tb.sv
